/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// byte step between sequential instructions
`define RV_INSTR_BYTES 32'd4

// halt cycles in decode before the freeze
`define RV_HALT_DRAIN 3

`endif

/* logic/rv_isa_pkg.sv */
`include "rv_consts.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_PASS
    } alu_op_t;

    // encoded as {funct3[2], funct3[0]}
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;

endpackage

/* logic/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // control bits carried from decode to writeback
    typedef struct packed {
        alu_op_t  alu_op;
        br_cond_t br_cond;
        logic     is_branch;
        logic     is_jump;
        logic     use_pc;
        logic     use_imm;
        logic     unsigned_cmp;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        wb_sel_t  wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rs1_need;
        logic     rs2_need;
    } decoded_t;

    // execute slot with resolved operands
    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        word_t    imm;
        word_t    rs1_val;
        word_t    rs2_val;
        reg_idx_t rd;
    } issue_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // one per producing stage
    typedef struct packed {
        logic     valid;
        logic     is_load;
        reg_idx_t rd;
        word_t    data;
    } fwd_t;

    typedef struct packed {
        logic     write;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic       cs;
        logic [3:0] we;
        word_t      addr;
        word_t      wdata;
    } dmem_req_t;

endpackage

/* logic/rv_reg_file.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_reg_file
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic     CLK,
    input  wb_t      wb,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [`RV_NUM_REGS];

    // x0 is never written
    always_ff @(posedge CLK) begin
        if (wb.write && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/rv_front_end.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_front_end
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  word_t     i_data,
    output word_t     i_addr,
    input  logic      stall,
    input  redirect_t redirect,
    output logic      run,
    output decoded_t  dec
);

    localparam int HALT_W = $clog2(`RV_HALT_DRAIN + 1);

    word_t             pc;
    word_t             fetch_pc;
    word_t             fetch_instr;
    logic              fetch_valid;
    logic [HALT_W-1:0] halt_cnt;
    logic              halt_word;
    opcode_t           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    alu_op_t           arith_op;
    imm_fmt_t          fmt;
    ctrl_t             ctrl;
    word_t             imm;
    logic              rs1_need;
    logic              rs2_need;

    ////////////////////////////////////////////////////////////////////////////
    // fetch and halt drain
    ////////////////////////////////////////////////////////////////////////////

    assign i_addr = pc;
    assign run    = (halt_cnt != HALT_W'(`RV_HALT_DRAIN));

    // zero word sits in decode until it drains or a redirect removes it
    assign halt_word = fetch_valid && (fetch_instr == '0) && !redirect.taken;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc          <= `RV_RESET_PC;
            fetch_valid <= 1'b0;
            halt_cnt    <= '0;
        end else if (run) begin
            // stops counting at the drain value since run drops there
            halt_cnt <= halt_word ? halt_cnt + 1'b1 : '0;
            if (redirect.taken) begin
                pc          <= redirect.target;
                fetch_valid <= 1'b0;
            end else if (!stall && !halt_word) begin
                pc          <= pc + `RV_INSTR_BYTES;
                fetch_pc    <= pc;
                fetch_instr <= i_data;
                fetch_valid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = opcode_t'(fetch_instr[6:0]);
    assign funct3 = fetch_instr[14:12];
    assign funct7 = fetch_instr[31:25];

    // shared by R and I arithmetic, srai carries funct7 in imm[11:5]
    always_comb begin
        unique case (funct3)
            3'd0:    arith_op = (opcode == OP_R && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    arith_op = ALU_SLL;
            3'd2:    arith_op = ALU_SLT;
            3'd3:    arith_op = ALU_SLT;
            3'd4:    arith_op = ALU_XOR;
            3'd5:    arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_cond = br_cond_t'({funct3[2], funct3[0]});
        ctrl.wb_sel  = WB_ALU;
        fmt          = IMM_I;
        rs1_need     = 1'b0;
        rs2_need     = 1'b0;
        unique case (opcode)
            OP_R, OP_IMM: begin
                ctrl.alu_op       = arith_op;
                ctrl.use_imm      = (opcode == OP_IMM);
                ctrl.unsigned_cmp = (funct3 == 3'd3);
                ctrl.reg_write    = 1'b1;
                rs1_need          = 1'b1;
                rs2_need          = (opcode == OP_R);
            end
            OP_LOAD: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LOAD;
                rs1_need       = 1'b1;
            end
            OP_STORE: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                fmt            = IMM_S;
                rs1_need       = 1'b1;
                rs2_need       = 1'b1;
            end
            OP_BRANCH: begin
                // ALU forms the target, comparator uses the registers
                ctrl.is_branch    = 1'b1;
                ctrl.use_pc       = 1'b1;
                ctrl.use_imm      = 1'b1;
                ctrl.unsigned_cmp = funct3[1];
                fmt               = IMM_B;
                rs1_need          = 1'b1;
                rs2_need          = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                ctrl.is_jump   = 1'b1;
                ctrl.use_pc    = (opcode == OP_JAL);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                fmt            = (opcode == OP_JAL) ? IMM_J : IMM_I;
                rs1_need       = (opcode == OP_JALR);
            end
            OP_LUI, OP_AUIPC: begin
                ctrl.alu_op    = (opcode == OP_LUI) ? ALU_PASS : ALU_ADD;
                ctrl.use_pc    = (opcode == OP_AUIPC);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                fmt            = IMM_U;
            end
            default: ;
        endcase
    end

    always_comb begin
        unique case (fmt)
            IMM_I: imm = {{21{fetch_instr[31]}}, fetch_instr[30:20]};
            IMM_S: imm = {{21{fetch_instr[31]}}, fetch_instr[30:25], fetch_instr[11:7]};
            IMM_B: imm = {{20{fetch_instr[31]}}, fetch_instr[7], fetch_instr[30:25],
                          fetch_instr[11:8], 1'b0};
            IMM_U: imm = {fetch_instr[31:12], 12'b0};
            default: imm = {{12{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                            fetch_instr[30:21], 1'b0};
        endcase
    end

    always_comb begin
        dec.valid    = fetch_valid && (fetch_instr != '0);
        dec.pc       = fetch_pc;
        dec.ctrl     = ctrl;
        dec.imm      = imm;
        dec.rs1      = fetch_instr[19:15];
        dec.rs2      = fetch_instr[24:20];
        dec.rd       = fetch_instr[11:7];
        dec.rs1_need = rs1_need;
        dec.rs2_need = rs2_need;
    end

    // a live instruction never follows a partial halt drain
    assert property (@(posedge CLK) disable iff (RST)
        dec.valid |-> (fetch_instr != '0) && (halt_cnt == '0));

endmodule

/* logic/rv_operand_stage.sv */
`timescale 1ns/1ps

module rv_operand_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      run,
    input  decoded_t  dec,
    input  redirect_t redirect,
    input  fwd_t      fwd_exe,
    input  fwd_t      fwd_mem,
    input  wb_t       wb,
    output logic      stall,
    output issue_t    iss
);

    word_t  rf_rd1;
    word_t  rf_rd2;
    logic   need1;
    logic   need2;
    issue_t iss_d;

    // youngest producer wins, checked last
    function automatic word_t pick_src(reg_idx_t idx, word_t rf_val,
                                       fwd_t fe, fwd_t fm, wb_t w);
        word_t val;
        val = rf_val;
        if (w.write && (w.rd == idx) && (idx != '0))
            val = w.data;
        if (fm.valid && (fm.rd == idx))
            val = fm.data;
        if (fe.valid && (fe.rd == idx))
            val = fe.data;
        return val;
    endfunction

    rv_reg_file i_rv_reg_file (
        .CLK (CLK),
        .wb  (wb),
        .rs1 (dec.rs1),
        .rs2 (dec.rs2),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2)
    );

    assign need1 = dec.valid && dec.rs1_need;
    assign need2 = dec.valid && dec.rs2_need;

    // load result only exists after the memory stage
    assign stall = fwd_exe.valid && fwd_exe.is_load &&
                   ((need1 && (dec.rs1 == fwd_exe.rd)) ||
                    (need2 && (dec.rs2 == fwd_exe.rd)));

    always_comb begin
        iss_d.valid   = dec.valid;
        iss_d.pc      = dec.pc;
        iss_d.ctrl    = dec.ctrl;
        iss_d.imm     = dec.imm;
        iss_d.rs1_val = pick_src(dec.rs1, rf_rd1, fwd_exe, fwd_mem, wb);
        iss_d.rs2_val = pick_src(dec.rs2, rf_rd2, fwd_exe, fwd_mem, wb);
        iss_d.rd      = dec.rd;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            iss.valid <= 1'b0;
        end else if (run) begin
            iss <= iss_d;
            // bubble on load-use or flush
            if (stall || redirect.taken) begin
                iss.valid <= 1'b0;
            end
        end
    end

    // the load causing a stall must be live in execute
    assert property (@(posedge CLK) disable iff (RST) stall |-> iss.valid);

endmodule

/* logic/rv_back_end.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_back_end
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      run,
    input  issue_t    iss,
    output redirect_t redirect,
    output fwd_t      fwd_exe,
    output fwd_t      fwd_mem,
    output dmem_req_t dmem_req,
    input  word_t     d_rdata,
    output wb_t       wb
);

    word_t    op_a;
    word_t    op_b;
    word_t    alu_y;
    word_t    link;
    word_t    ex_result;
    logic     br_true;
    logic     mem_valid;
    ctrl_t    mem_ctrl;
    word_t    mem_result;
    word_t    mem_wdata;
    reg_idx_t mem_rd;
    word_t    mem_data;
    logic     mem_fire;

    function automatic logic less_than(word_t a, word_t b, logic uns);
        return uns ? (a < b) : ($signed(a) < $signed(b));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////////////////////

    assign op_a = iss.ctrl.use_pc ? iss.pc : iss.rs1_val;
    assign op_b = iss.ctrl.use_imm ? iss.imm : iss.rs2_val;
    assign link = iss.pc + `RV_INSTR_BYTES;

    always_comb begin
        unique case (iss.ctrl.alu_op)
            ALU_SUB:  alu_y = op_a - op_b;
            ALU_XOR:  alu_y = op_a ^ op_b;
            ALU_OR:   alu_y = op_a | op_b;
            ALU_AND:  alu_y = op_a & op_b;
            ALU_SLL:  alu_y = op_a << op_b[4:0];
            ALU_SRL:  alu_y = op_a >> op_b[4:0];
            ALU_SRA:  alu_y = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:  alu_y = word_t'(less_than(op_a, op_b, iss.ctrl.unsigned_cmp));
            ALU_PASS: alu_y = op_b;
            default:  alu_y = op_a + op_b;
        endcase
    end

    // branch compare always on the register operands
    always_comb begin
        unique case (iss.ctrl.br_cond)
            BR_EQ:   br_true = (iss.rs1_val == iss.rs2_val);
            BR_NE:   br_true = (iss.rs1_val != iss.rs2_val);
            BR_LT:   br_true = less_than(iss.rs1_val, iss.rs2_val, iss.ctrl.unsigned_cmp);
            default: br_true = !less_than(iss.rs1_val, iss.rs2_val, iss.ctrl.unsigned_cmp);
        endcase
    end

    always_comb begin
        redirect.taken  = iss.valid && (iss.ctrl.is_jump || (iss.ctrl.is_branch && br_true));
        redirect.target = {alu_y[`RV_XLEN-1:1], 1'b0};
    end

    assign ex_result = (iss.ctrl.wb_sel == WB_LINK) ? link : alu_y;

    always_comb begin
        fwd_exe.valid   = iss.valid && iss.ctrl.reg_write && (iss.rd != '0);
        fwd_exe.is_load = iss.ctrl.mem_read;
        fwd_exe.rd      = iss.rd;
        fwd_exe.data    = ex_result;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory and writeback
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            mem_valid <= 1'b0;
            wb.write  <= 1'b0;
        end else if (run) begin
            mem_valid  <= iss.valid;
            mem_ctrl   <= iss.ctrl;
            mem_result <= ex_result;
            mem_wdata  <= iss.rs2_val;
            mem_rd     <= iss.rd;
            wb.write   <= mem_valid && mem_ctrl.reg_write;
            wb.rd      <= mem_rd;
            wb.data    <= mem_data;
        end
    end

    // no requests once frozen
    assign mem_fire = mem_valid && run;
    assign mem_data = (mem_ctrl.wb_sel == WB_LOAD) ? d_rdata : mem_result;

    always_comb begin
        dmem_req.cs    = mem_fire && (mem_ctrl.mem_read || mem_ctrl.mem_write);
        dmem_req.we    = (mem_fire && mem_ctrl.mem_write) ? 4'b1111 : 4'b0000;
        dmem_req.addr  = {mem_result[`RV_XLEN-1:2], 2'b00};
        dmem_req.wdata = mem_wdata;
    end

    always_comb begin
        fwd_mem.valid   = mem_valid && mem_ctrl.reg_write && (mem_rd != '0);
        fwd_mem.is_load = mem_ctrl.mem_read;
        fwd_mem.rd      = mem_rd;
        fwd_mem.data    = mem_data;
    end

    // a write strobe comes from a store issued to execute one cycle earlier
    assert property (@(posedge CLK) disable iff (RST)
        (dmem_req.we != '0) |-> dmem_req.cs && $past(iss.valid && iss.ctrl.mem_write));

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    output word_t     i_addr,
    input  word_t     i_data,
    output dmem_req_t dmem_req,
    input  word_t     d_rdata,
    output logic      halted
);

    decoded_t  dec;
    issue_t    iss;
    redirect_t redirect;
    fwd_t      fwd_exe;
    fwd_t      fwd_mem;
    wb_t       wb;
    logic      stall;
    logic      run;

    assign halted = ~run;

    rv_front_end i_rv_front_end (
        .CLK      (CLK),
        .RST      (RST),
        .i_data   (i_data),
        .i_addr   (i_addr),
        .stall    (stall),
        .redirect (redirect),
        .run      (run),
        .dec      (dec)
    );

    rv_operand_stage i_rv_operand_stage (
        .CLK      (CLK),
        .RST      (RST),
        .run      (run),
        .dec      (dec),
        .redirect (redirect),
        .fwd_exe  (fwd_exe),
        .fwd_mem  (fwd_mem),
        .wb       (wb),
        .stall    (stall),
        .iss      (iss)
    );

    rv_back_end i_rv_back_end (
        .CLK      (CLK),
        .RST      (RST),
        .run      (run),
        .iss      (iss),
        .redirect (redirect),
        .fwd_exe  (fwd_exe),
        .fwd_mem  (fwd_mem),
        .dmem_req (dmem_req),
        .d_rdata  (d_rdata),
        .wb       (wb)
    );

endmodule

/* test/rv_mem_model.sv */
`timescale 1ns/1ps

module rv_mem_model
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  logic      CLK,
    input  word_t     i_addr,
    output word_t     i_data,
    input  dmem_req_t dmem_req,
    output word_t     d_rdata
);

    localparam int IDX_W = $clog2(WORDS);

    // separate instruction and data arrays, filled before reset ends
    word_t imem [WORDS];
    word_t dmem [WORDS];

    logic [IDX_W-1:0] i_idx;
    logic [IDX_W-1:0] d_idx;

    assign i_idx = i_addr[IDX_W+1:2];
    assign d_idx = dmem_req.addr[IDX_W+1:2];

    // both ports answer in the same cycle
    assign i_data  = imem[i_idx];
    assign d_rdata = dmem[d_idx];

    // byte lanes follow the write mask
    always @(posedge CLK) begin
        if (dmem_req.cs) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.we[b]) begin
                    dmem[d_idx][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int    MEM_WORDS    = 256;
    localparam int    HALT_TIMEOUT = 5000;
    localparam word_t SLOT_BASE    = 32'h0000_0100;

    logic      CLK;
    logic      RST;
    word_t     i_addr;
    word_t     i_data;
    dmem_req_t dmem_req;
    word_t     d_rdata;
    logic      halted;

    word_t prog_pc;
    word_t next_slot;
    word_t init_data [MEM_WORDS];

    // result table with one row per stored word
    string chk_name [$];
    word_t chk_addr [$];
    word_t chk_value [$];

    rv_core i_rv_core (
        .CLK      (CLK),
        .RST      (RST),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .dmem_req (dmem_req),
        .d_rdata  (d_rdata),
        .halted   (halted)
    );

    rv_mem_model #(.WORDS(MEM_WORDS)) i_rv_mem_model (
        .CLK      (CLK),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .dmem_req (dmem_req),
        .d_rdata  (d_rdata)
    );

    always #5 CLK = ~CLK;

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %08h, actual %08h",
                                name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_R};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd, opcode_t op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    // sw rs2, addr(x0)
    function automatic word_t store_word(int rs2, word_t addr);
        return {addr[11:5], 5'(rs2), 5'd0, 3'd2, addr[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(int imm20, int rd, opcode_t op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic word_t j_type(int off, int rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OP_JAL};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // program building
    ////////////////////////////////////////////////////////////////////////////

    task automatic emit(word_t instr);
        i_rv_mem_model.imem[int'(prog_pc >> 2)] = instr;
        prog_pc += `RV_INSTR_BYTES;
    endtask

    task automatic expect_word(string name, word_t addr, word_t value);
        chk_name.push_back(name);
        chk_addr.push_back(addr);
        chk_value.push_back(value);
    endtask

    task automatic store_result(string name, int rs, word_t value);
        emit(store_word(rs, next_slot));
        expect_word(name, next_slot, value);
        next_slot += 32'd4;
    endtask

    // every ALU case writes x3
    task automatic alu_case(string name, word_t instr, word_t value);
        emit(instr);
        store_result(name, 3, value);
    endtask

    // the two slots behind a taken transfer leave their word untouched
    task automatic flushed_pair(string name);
        emit(store_word(1, next_slot));
        emit(store_word(2, next_slot));
        expect_word({name, " flushed"}, next_slot, init_data[int'(next_slot >> 2)]);
        next_slot += 32'd4;
    endtask

    // x29 counts taken targets and x28 counts fall-through
    task automatic branch_case(string name, int f3, int rs1, int rs2, bit taken);
        if (taken) begin
            emit(b_type(f3, rs1, rs2, 12));
            flushed_pair(name);
            emit(i_type(1, 29, 0, 29, OP_IMM));
        end else begin
            emit(b_type(f3, rs1, rs2, 8));
            emit(i_type(1, 28, 0, 28, OP_IMM));
        end
    endtask

    // x1 = -20 and x2 = 7 for the whole program
    task automatic build_alu_tests();
        emit(i_type(-20, 0, 0, 1, OP_IMM));
        emit(i_type(7, 0, 0, 2, OP_IMM));
        alu_case("add",   r_type('h00, 2, 1, 0, 3), 32'hffff_fff3);
        alu_case("sub",   r_type('h20, 2, 1, 0, 3), 32'hffff_ffe5);
        alu_case("sll",   r_type('h00, 2, 2, 1, 3), 32'h0000_0380);
        alu_case("slt",   r_type('h00, 2, 1, 2, 3), 32'h0000_0001);
        alu_case("sltu",  r_type('h00, 2, 1, 3, 3), 32'h0000_0000);
        alu_case("xor",   r_type('h00, 2, 1, 4, 3), 32'hffff_ffeb);
        alu_case("srl",   r_type('h00, 2, 1, 5, 3), 32'h01ff_ffff);
        alu_case("sra",   r_type('h20, 2, 1, 5, 3), 32'hffff_ffff);
        alu_case("or",    r_type('h00, 2, 1, 6, 3), 32'hffff_ffef);
        alu_case("and",   r_type('h00, 2, 1, 7, 3), 32'h0000_0004);
        alu_case("addi",  i_type(100, 1, 0, 3, OP_IMM), 32'h0000_0050);
        alu_case("slti",  i_type(-19, 1, 2, 3, OP_IMM), 32'h0000_0001);
        alu_case("sltiu", i_type(5, 1, 3, 3, OP_IMM), 32'h0000_0000);
        alu_case("xori",  i_type('h0f0, 1, 4, 3, OP_IMM), 32'hffff_ff1c);
        alu_case("ori",   i_type('h100, 2, 6, 3, OP_IMM), 32'h0000_0107);
        alu_case("andi",  i_type('h0ff, 1, 7, 3, OP_IMM), 32'h0000_00ec);
        alu_case("slli",  i_type(4, 2, 1, 3, OP_IMM), 32'h0000_0070);
        alu_case("srli",  i_type(28, 1, 5, 3, OP_IMM), 32'h0000_000f);
        alu_case("srai",  i_type('h402, 1, 5, 3, OP_IMM), 32'hffff_fffb);
        alu_case("lui",   u_type('habcde, 3, OP_LUI), 32'habcd_e000);
        alu_case("auipc", u_type('h00012, 3, OP_AUIPC), prog_pc + 32'h0001_2000);
    endtask

    task automatic build_pipeline_tests();
        word_t load_src;
        emit(i_type(100, 0, 0, 21, OP_IMM));
        emit(i_type(1, 21, 0, 22, OP_IMM));
        emit(i_type(2, 21, 0, 23, OP_IMM));
        emit(i_type(3, 21, 0, 24, OP_IMM));
        emit(r_type('h00, 24, 22, 0, 25));
        store_result("fwd dist 1", 22, 32'd101);
        store_result("fwd dist 2", 23, 32'd102);
        store_result("fwd dist 3", 24, 32'd103);
        load_src = next_slot;
        store_result("fwd chain", 25, 32'd204);
        // load then an immediate consumer
        emit(i_type(int'(load_src), 0, 2, 26, OP_LOAD));
        emit(r_type('h00, 2, 26, 0, 27));
        store_result("load use", 27, 32'd211);
    endtask

    task automatic build_control_tests();
        word_t link_pc;
        emit(i_type(0, 0, 0, 28, OP_IMM));
        emit(i_type(0, 0, 0, 29, OP_IMM));
        branch_case("beq taken",  0, 2, 2, 1'b1);
        branch_case("beq",        0, 1, 2, 1'b0);
        branch_case("bne taken",  1, 1, 2, 1'b1);
        branch_case("bne",        1, 2, 2, 1'b0);
        branch_case("blt taken",  4, 1, 2, 1'b1);
        branch_case("blt",        4, 2, 1, 1'b0);
        branch_case("bge taken",  5, 2, 1, 1'b1);
        branch_case("bge",        5, 1, 2, 1'b0);
        branch_case("bltu taken", 6, 2, 1, 1'b1);
        branch_case("bltu",       6, 1, 2, 1'b0);
        branch_case("bgeu taken", 7, 1, 2, 1'b1);
        branch_case("bgeu",       7, 2, 1, 1'b0);
        store_result("not taken count", 28, 32'd6);
        store_result("taken count", 29, 32'd6);
        link_pc = prog_pc;
        emit(j_type(12, 30));
        flushed_pair("jal");
        store_result("jal link", 30, link_pc + 32'd4);
        // x5 points 8 past the jalr and the offset adds the last 4
        emit(i_type(int'(prog_pc) + 12, 0, 0, 5, OP_IMM));
        link_pc = prog_pc;
        emit(i_type(4, 5, 0, 31, OP_JALR));
        flushed_pair("jalr");
        store_result("jalr link", 31, link_pc + 32'd4);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halted) begin
            abort_run($sformatf("halted did not rise within %0d cycles", HALT_TIMEOUT));
        end
    endtask

    // once frozen the data port must stay quiet
    always @(negedge CLK) begin
        if (!RST && halted) begin
            check_value("store after halt", 32'd0, 32'({dmem_req.cs, dmem_req.we}));
        end
    end

    initial begin
        CLK       = 1'b0;
        RST       = 1'b1;
        prog_pc   = `RV_RESET_PC;
        next_slot = SLOT_BASE;
        void'($urandom(32'hb09));
        for (int k = 0; k < MEM_WORDS; k++) begin
            init_data[k] = $urandom();
            i_rv_mem_model.dmem[k] = init_data[k];
            i_rv_mem_model.imem[k] = '0;
        end

        build_alu_tests();
        build_pipeline_tests();
        build_control_tests();
        store_result("last store", 2, 32'd7);
        emit(32'h0000_0000);

        repeat (10) @(negedge CLK);
        check_value("halted in reset", 32'd0, 32'(halted));
        check_value("pc in reset", `RV_RESET_PC, i_addr);
        check_value("dmem cs in reset", 32'd0, 32'(dmem_req.cs));
        check_value("dmem we in reset", 32'd0, 32'(dmem_req.we));
        RST = 1'b0;

        wait_for_halt();
        repeat (10) @(negedge CLK);
        check_value("halted holds", 32'd1, 32'(halted));

        for (int k = 0; k < chk_name.size(); k++) begin
            check_value(chk_name[k], chk_value[k],
                        i_rv_mem_model.dmem[int'(chk_addr[k] >> 2)]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_reg_file.sv
logic/rv_front_end.sv
logic/rv_operand_stage.sv
logic/rv_back_end.sv
logic/rv_core.sv
test/rv_mem_model.sv
test/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build the core with its testbench, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rv_core \
    -o tb_rv_core \
    && ./obj_dir/tb_rv_core | tee sim.log \
    || echo "build or simulation stopped with an error"
grep -qs "Simulation PASSED" sim.log && echo "run passed" && exit 0 || exit 1
